// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   localparam int TAG_W = 5;
   localparam int INDEX_W = 8;
   localparam int OFFSET_W = 3;
   localparam int WORD_W = 16;
   localparam int SETS = 1 << INDEX_W;
   localparam int LINE_WORDS = 4;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // Processor byte address split into its fields
   typedef struct packed {
      tag_t    tag;
      index_t  index;
      offset_t offset;
   } addr_fields_t;

   // Shared request from the controller to both ways
   typedef struct packed {
      logic    comp;
      logic    valid_in;
      tag_t    tag;
      index_t  index;
      offset_t offset;
      word_t   data;
   } line_access_t;

   typedef struct packed {
      logic  hit;
      logic  dirty;
      logic  valid;
      tag_t  tag;
      word_t data;
   } way_status_t;

endpackage

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

   localparam int BANKS = 4;

   typedef logic [1:0] bank_t;

   typedef struct packed {
      logic             rd;
      logic             wr;
      cache_pkg::word_t addr;
      cache_pkg::word_t data;
   } mem_req_t;

   // Words interleave across banks
   function automatic bank_t bank_of(input cache_pkg::word_t a);
      return a[2:1];
   endfunction

endpackage

`default_nettype wire

// ==== hdl/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          en,
   input  wire                          wr,
   input  wire cache_pkg::line_access_t acc,
   output cache_pkg::way_status_t       status
);

   localparam int WSEL_W = $clog2(cache_pkg::LINE_WORDS);

   cache_pkg::tag_t  tag_mem  [cache_pkg::SETS];
   cache_pkg::word_t data_mem [cache_pkg::SETS][cache_pkg::LINE_WORDS];
   logic [cache_pkg::SETS-1:0] valid_bits;
   logic [cache_pkg::SETS-1:0] dirty_bits;

   logic [WSEL_W-1:0] word_sel;
   logic              tag_match;
   logic              write_acc;
   logic              write_cmp;

   // Offset bit 0 is the byte within a word
   assign word_sel = acc.offset[WSEL_W:1];
   assign tag_match = valid_bits[acc.index] && (tag_mem[acc.index] == acc.tag);

   // Access mode fills a line, compare mode writes only on a hit
   assign write_acc = en && wr && !acc.comp;
   assign write_cmp = en && wr && acc.comp && tag_match;

   always_comb begin
      status.hit = en && acc.comp && tag_match;
      status.dirty = dirty_bits[acc.index];
      status.valid = valid_bits[acc.index];
      status.tag = tag_mem[acc.index];
      status.data = data_mem[acc.index][word_sel];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (write_acc) begin
         valid_bits[acc.index] <= acc.valid_in;
         dirty_bits[acc.index] <= 1'b0;
      end else if (write_cmp) begin
         dirty_bits[acc.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (write_acc || write_cmp) begin
         data_mem[acc.index][word_sel] <= acc.data;
      end
      if (write_acc) begin
         tag_mem[acc.index] <= acc.tag;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/four_bank_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module four_bank_mem #(
   parameter int BANK_LAT = 4
) (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire mem_pkg::mem_req_t     req,
   output cache_pkg::word_t           rd_data,
   output logic                       rd_valid,
   output logic [mem_pkg::BANKS-1:0]  busy
);

   localparam int WORDS = 32768;
   localparam int ROWS = WORDS / mem_pkg::BANKS;
   localparam int ROW_W = $clog2(ROWS);
   localparam int CNT_W = $clog2(BANK_LAT + 1);

   cache_pkg::word_t bank_mem [mem_pkg::BANKS][ROWS] = '{default: '0};
   cache_pkg::word_t data_q [mem_pkg::BANKS];
   logic [CNT_W-1:0] cnt [mem_pkg::BANKS];
   logic [mem_pkg::BANKS-1:0] rd_pend;
   logic [mem_pkg::BANKS-1:0] ready;

   mem_pkg::bank_t   req_bank;
   logic [ROW_W-1:0] req_row;

   assign req_bank = mem_pkg::bank_of(req.addr);
   assign req_row = req.addr[ROW_W+2:3];

   always_comb begin
      for (int b = 0; b < mem_pkg::BANKS; b++) begin
         busy[b] = (cnt[b] != '0);
         // Read data leaves on the last busy cycle
         ready[b] = rd_pend[b] && (cnt[b] == CNT_W'(1));
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '{default: '0};
         rd_pend <= '0;
      end else begin
         for (int b = 0; b < mem_pkg::BANKS; b++) begin
            if ((req.rd || req.wr) && (req_bank == mem_pkg::bank_t'(b))) begin
               cnt[b] <= CNT_W'(BANK_LAT);
               rd_pend[b] <= req.rd;
            end else if (cnt[b] != '0) begin
               cnt[b] <= cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req.wr) begin
         bank_mem[req_bank][req_row] <= req.data;
      end
      if (req.rd) begin
         data_q[req_bank] <= bank_mem[req_bank][req_row];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= |ready;
      end
   end

   // At most one bank finishes per cycle
   always_ff @(posedge clk) begin
      for (int b = 0; b < mem_pkg::BANKS; b++) begin
         if (ready[b]) begin
            rd_data <= data_q[b];
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire cache_pkg::word_t       addr,
   input  wire cache_pkg::word_t       data_in,
   input  wire                         rd,
   input  wire                         wr,
   input  wire cache_pkg::way_status_t status0,
   input  wire cache_pkg::way_status_t status1,
   output cache_pkg::line_access_t     acc,
   output logic [1:0]                  way_en,
   output logic [1:0]                  way_wr,
   output mem_pkg::mem_req_t           mem_req,
   input  wire cache_pkg::word_t       rd_data,
   input  wire                         rd_valid,
   input  wire [mem_pkg::BANKS-1:0]    busy,
   output cache_pkg::word_t            data_out,
   output logic                        done,
   output logic                        stall,
   output logic                        cache_hit,
   output logic                        err
);

   typedef enum logic [2:0] {
      idle, compare, write_back, fill_issue,
      fill_wait, finish_write, respond
   } state_t;

   state_t state;
   state_t state_next;

   cache_pkg::addr_fields_t req_fields;
   cache_pkg::tag_t         tag_q;
   cache_pkg::index_t       index_q;
   cache_pkg::offset_t      offset_q;
   cache_pkg::word_t        data_q;
   cache_pkg::way_status_t  vstat;
   logic                    wr_q;
   logic                    victim_q;
   logic                    err_q;
   mem_pkg::bank_t          issue_cnt;
   mem_pkg::bank_t          ret_cnt;
   logic [cache_pkg::SETS-1:0] mru;

   logic good_req;
   logic bad_req;
   logic hit;
   logic hit_way;
   logic victim_c;
   logic victim;
   logic filling;
   logic issue_ok;

   assign req_fields = addr;
   assign good_req = (rd ^ wr) && !addr[0];
   assign bad_req = (rd || wr) && (addr[0] || (rd && wr));

   assign hit = status0.hit || status1.hit;
   assign hit_way = status1.hit;

   // Empty way first, else the one not used last
   always_comb begin
      if (!status0.valid) begin
         victim_c = 1'b0;
      end else if (!status1.valid) begin
         victim_c = 1'b1;
      end else begin
         victim_c = !mru[index_q];
      end
   end

   assign victim = (state == compare) ? victim_c : victim_q;
   assign vstat = victim ? status1 : status0;
   assign filling = (state == fill_issue) || (state == fill_wait);
   // Word k of a line sits in bank k
   assign issue_ok = !busy[issue_cnt];

   always_comb begin
      acc.comp = (state == compare) || (state == finish_write);
      acc.valid_in = 1'b1;
      acc.tag = tag_q;
      acc.index = index_q;
      acc.data = filling ? rd_data : data_q;
      case (state)
         write_back: acc.offset = {issue_cnt, 1'b0};
         fill_issue, fill_wait: acc.offset = {ret_cnt, 1'b0};
         default: acc.offset = offset_q;
      endcase
   end

   always_comb begin
      way_en = 2'b00;
      way_wr = 2'b00;
      if (state == compare) begin
         way_en = 2'b11;
         way_wr[hit_way] = hit && wr_q;
      end else if (state != idle) begin
         way_en[victim_q] = 1'b1;
         way_wr[victim_q] = (filling && rd_valid) || (state == finish_write);
      end
   end

   always_comb begin
      mem_req.rd = (state == fill_issue) && issue_ok;
      mem_req.wr = (state == write_back) && issue_ok;
      mem_req.addr = {(state == write_back) ? vstat.tag : tag_q, index_q, issue_cnt, 1'b0};
      mem_req.data = vstat.data;
   end

   assign data_out = ((state == compare) ? hit_way : victim_q) ? status1.data : status0.data;
   assign cache_hit = (state == compare) && hit;
   assign done = cache_hit || (state == respond);
   assign stall = ((state == compare) && !hit) || (state == write_back) || filling
                  || (state == finish_write);
   assign err = err_q;

   always_comb begin
      state_next = state;
      case (state)
         idle:
            if (good_req) state_next = compare;
         compare:
            if (hit) state_next = idle;
            else if (vstat.valid && vstat.dirty) state_next = write_back;
            else state_next = fill_issue;
         write_back:
            if (issue_ok && issue_cnt == 2'd3) state_next = fill_issue;
         fill_issue:
            if (issue_ok && issue_cnt == 2'd3) state_next = fill_wait;
         fill_wait:
            if (rd_valid && ret_cnt == 2'd3) state_next = wr_q ? finish_write : respond;
         finish_write:
            state_next = respond;
         default:
            state_next = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
         err_q <= 1'b0;
         wr_q <= 1'b0;
         victim_q <= 1'b0;
         issue_cnt <= '0;
         ret_cnt <= '0;
         mru <= '0;
      end else begin
         state <= state_next;
         err_q <= (state == idle) && bad_req;
         if (state == idle && good_req) begin
            wr_q <= wr;
         end
         if (state == compare) begin
            victim_q <= victim_c;
            issue_cnt <= '0;
            ret_cnt <= '0;
         end
         // Wraps to zero between write-back and fill
         if ((state == write_back || state == fill_issue) && issue_ok) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (filling && rd_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
         if (cache_hit) begin
            mru[index_q] <= hit_way;
         end else if (state == respond) begin
            mru[index_q] <= victim_q;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == idle && good_req) begin
         tag_q <= req_fields.tag;
         index_q <= req_fields.index;
         offset_q <= req_fields.offset;
         data_q <= data_in;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system #(
   parameter int BANK_LAT = 4
) (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire cache_pkg::word_t addr,
   input  wire cache_pkg::word_t data_in,
   input  wire                   rd,
   input  wire                   wr,
   output cache_pkg::word_t      data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);

   cache_pkg::line_access_t   acc;
   cache_pkg::way_status_t    status0;
   cache_pkg::way_status_t    status1;
   logic [1:0]                way_en;
   logic [1:0]                way_wr;
   mem_pkg::mem_req_t         mem_req;
   cache_pkg::word_t          rd_data;
   logic                      rd_valid;
   logic [mem_pkg::BANKS-1:0] busy;

   cache_ctrl ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .status0   (status0),
      .status1   (status1),
      .acc       (acc),
      .way_en    (way_en),
      .way_wr    (way_wr),
      .mem_req   (mem_req),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .busy      (busy),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   cache_way way0_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .en     (way_en[0]),
      .wr     (way_wr[0]),
      .acc    (acc),
      .status (status0)
   );

   cache_way way1_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .en     (way_en[1]),
      .wr     (way_wr[1]),
      .acc    (acc),
      .status (status1)
   );

   four_bank_mem #(
      .BANK_LAT (BANK_LAT)
   ) mem_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (mem_req),
      .rd_data  (rd_data),
      .rd_valid (rd_valid),
      .busy     (busy)
   );

endmodule

`default_nettype wire

// ==== bench/mem_system_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system_assert (
   input wire                      clk,
   input wire                      rst_n,
   input wire                      done,
   input wire                      stall,
   input wire                      cache_hit,
   input wire mem_pkg::mem_req_t   req,
   input wire [mem_pkg::BANKS-1:0] busy
);

   int fails = 0;

   done_not_with_stall: assert property (@(posedge clk) disable iff (!rst_n)
      !(done && stall)) else begin
      $error("done and stall are high in the same cycle");
      fails++;
   end

   hit_only_with_done: assert property (@(posedge clk) disable iff (!rst_n)
      cache_hit |-> done) else begin
      $error("cache_hit is high without done");
      fails++;
   end

   one_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
      !(req.rd && req.wr)) else begin
      $error("memory read and write requested together");
      fails++;
   end

   // Bank number is address bits 2 to 1
   idle_bank_only: assert property (@(posedge clk) disable iff (!rst_n)
      (req.rd || req.wr) |-> !busy[req.addr[2:1]]) else begin
      $error("memory request sent to a busy bank");
      fails++;
   end

endmodule

bind cache_ctrl mem_system_assert ctrl_chk_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .done      (done),
   .stall     (stall),
   .cache_hit (cache_hit),
   .req       (mem_req),
   .busy      (busy)
);

bind four_bank_mem mem_system_assert mem_chk_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .done      (1'b0),
   .stall     (1'b0),
   .cache_hit (1'b0),
   .req       (req),
   .busy      (busy)
);

`default_nettype wire

// ==== bench/mem_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;

   localparam int CLK_PERIOD = 8;
   localparam int REQ_LIMIT = 40;
   localparam int RAND_OPS = 400;
   localparam int TOTAL_REQS = 1 + 2 + 4 + RAND_OPS + 4;

   logic             clk;
   logic             rst_n;
   cache_pkg::word_t addr;
   cache_pkg::word_t data_in;
   cache_pkg::word_t data_out;
   logic             rd;
   logic             wr;
   logic             done;
   logic             stall;
   logic             cache_hit;
   logic             err;

   // Flat word memory model plus per-set tags, valid and LRU
   cache_pkg::word_t mem_model [32768] = '{default: '0};
   cache_pkg::tag_t  tag_model [cache_pkg::SETS][2];
   logic [1:0]       valid_model [cache_pkg::SETS] = '{default: '0};
   logic             mru_model [cache_pkg::SETS] = '{default: '0};

   logic [31:0]      lfsr = 32'h0c069a13;
   logic             exp_err;
   logic             exp_hit;
   logic             exp_rd;
   cache_pkg::word_t exp_data;
   time              req_edge;
   int               issued_cnt = 0;
   int               answered_cnt = 0;
   int               check_errs = 0;
   int               seq_errs = 0;
   int               last_errs = 0;
   int               tests_run = 0;

   mem_system #(
      .BANK_LAT (4)
   ) mem_system_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (TOTAL_REQS * REQ_LIMIT + 100) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display("Verification failed");
      $finish;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic void predict(input cache_pkg::word_t a, input logic r, input logic w,
                                   input cache_pkg::word_t d);
      cache_pkg::tag_t   t;
      cache_pkg::index_t idx;
      int                way;
      t = a[15:11];
      idx = a[10:3];
      way = -1;
      exp_err = a[0] || (r && w);
      exp_hit = 1'b0;
      exp_rd = r;
      exp_data = '0;
      if (exp_err) begin
         return;
      end
      for (int k = 0; k < 2; k++) begin
         if (valid_model[idx][k] && tag_model[idx][k] == t) begin
            way = k;
         end
      end
      exp_hit = (way >= 0);
      if (way < 0) begin
         // Empty way 0, then empty way 1, then the least recently used
         if (!valid_model[idx][0]) begin
            way = 0;
         end else if (!valid_model[idx][1]) begin
            way = 1;
         end else begin
            way = mru_model[idx] ? 0 : 1;
         end
         valid_model[idx][way] = 1'b1;
         tag_model[idx][way] = t;
      end
      mru_model[idx] = (way == 1);
      if (w) begin
         mem_model[a[15:1]] = d;
      end
      exp_data = mem_model[a[15:1]];
   endfunction

   task automatic issue(input cache_pkg::word_t a, input logic r, input logic w,
                        input cache_pkg::word_t d);
      int n;
      n = 0;
      predict(a, r, w, d);
      @(posedge clk);
      #1;
      addr = a;
      data_in = d;
      rd = r;
      wr = w;
      @(posedge clk);
      req_edge = $time;
      issued_cnt++;
      #1;
      rd = 1'b0;
      wr = 1'b0;
      while (answered_cnt != issued_cnt && n < REQ_LIMIT) begin
         @(posedge clk);
         n++;
      end
      assert (answered_cnt == issued_cnt) else begin
         $display("Request to address %h got neither done nor err in %0d cycles", a, REQ_LIMIT);
         seq_errs++;
         answered_cnt = issued_cnt;
      end
      // Give a stray done after an error time to show up
      if (exp_err) begin
         repeat (4) @(posedge clk);
      end
   endtask

   task automatic end_test(input string name);
      int now_errs;
      now_errs = seq_errs + check_errs;
      $display("%s: %s (%0d errors)", name, (now_errs == last_errs) ? "ok" : "FAIL",
               now_errs - last_errs);
      last_errs = now_errs;
      tests_run++;
   endtask

   always @(negedge clk) begin
      if (rst_n && (done || err)) begin
         assert (issued_cnt != answered_cnt) else begin
            $display("done or err pulsed at t=%0t with no request outstanding", $time);
            check_errs++;
         end
         if (issued_cnt != answered_cnt) begin
            assert (err == exp_err) else begin
               $display("[FAIL] t=%0t err expected %b got %b", $time, exp_err, err);
               check_errs++;
            end
            assert (done == !exp_err) else begin
               $display("[FAIL] t=%0t done expected %b got %b", $time, !exp_err, done);
               check_errs++;
            end
            if (done) begin
               assert (cache_hit == exp_hit) else begin
                  $display("[FAIL] t=%0t cache_hit expected %b got %b", $time, exp_hit,
                           cache_hit);
                  check_errs++;
               end
               if (exp_rd) begin
                  assert (data_out == exp_data) else begin
                     $display("[FAIL] t=%0t data_out expected %h got %h", $time, exp_data,
                              data_out);
                     check_errs++;
                  end
               end
               if (exp_hit) begin
                  assert (($time - req_edge) == time'(CLK_PERIOD / 2)) else begin
                     $display("Hit at t=%0t did not finish one cycle after its request",
                              $time);
                     check_errs++;
                  end
               end
            end
            answered_cnt++;
         end
      end else if (issued_cnt != answered_cnt && !exp_err && !exp_hit) begin
         assert (stall) else begin
            $display("[FAIL] t=%0t stall expected 1 got %b", $time, stall);
            check_errs++;
         end
      end
   end

   initial begin
      cache_pkg::word_t a;
      cache_pkg::word_t d;
      logic             w;
      int               total;
      rst_n = 1'b0;
      rd = 1'b0;
      wr = 1'b0;
      addr = '0;
      data_in = '0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      assert (!done && !stall && !cache_hit && !err) else begin
         $display("Outputs are not all low after reset");
         seq_errs++;
      end
      issue(16'h1234, 1'b1, 1'b0, 16'h0000);
      end_test("reset and first read");

      issue(16'h2a48, 1'b0, 1'b1, 16'hbeef);
      issue(16'h2a48, 1'b1, 1'b0, 16'h0000);
      end_test("write then read hit");

      // Third tag in one set evicts the first, which is dirty
      for (int t = 1; t <= 3; t++) begin
         issue({5'(t), 8'h5c, 3'b010}, 1'b0, 1'b1, 16'(16'h1111 * t));
      end
      issue({5'd1, 8'h5c, 3'b010}, 1'b1, 1'b0, 16'h0000);
      end_test("eviction with write-back");

      for (int i = 0; i < RAND_OPS; i++) begin
         w = 1'(rand_bits(1));
         a = {3'b000, 2'(rand_bits(2)), 6'b000000, 2'(rand_bits(2)), 2'(rand_bits(2)), 1'b0};
         d = 16'(rand_bits(16));
         issue(a, !w, w, d);
      end
      end_test("random mixed run");

      issue(16'h7f30, 1'b0, 1'b1, 16'h5a5a);
      issue(16'h7f31, 1'b0, 1'b1, 16'hdead);
      issue(16'h7f30, 1'b1, 1'b1, 16'hdead);
      issue(16'h7f30, 1'b1, 1'b0, 16'h0000);
      end_test("bad requests");

      total = seq_errs + check_errs + mem_system_i.ctrl_i.ctrl_chk_i.fails
              + mem_system_i.mem_i.mem_chk_i.fails;
      $display("Tests run: %0d, total errors: %0d", tests_run, total);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_way.sv
hdl/four_bank_mem.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
bench/mem_system_assert.sv
bench/mem_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module mem_system_tb -Mdir obj_dir

./obj_dir/Vmem_system_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Verification passed" sim.log; then
   exit 0
fi
exit 1
